//--- hdl/aes_types_pkg.sv
/*
 * Data and control types shared by the AES-128 engine and its testbench.
 * Blocks are column major. Word 0 sits in the top bits, row 0 leads each word.
 */

package aes_types_pkg;

	////////////////////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////////////////////

	// one byte of state or key
	typedef logic [7:0] aes_byte_t;

	// one column, row 0 in the top byte
	typedef aes_byte_t [0:3] aes_word_t;

	// full 128-bit block as four columns, w[0] in bits 127:96
	typedef aes_word_t [0:3] aes_block_t;

	// what a requester presents with req
	typedef struct packed {
		aes_block_t key;
		aes_block_t plaintext;
	} aes_request_t;

	////////////////////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////////////////////

	// controller to datapath, one bundle for key and state paths
	typedef struct packed {
		// capture a new key and plaintext
		logic load;
		// advance one round
		logic step;
		// last round, MixColumns is skipped
		logic final_round;
	} round_ctrl_t;

	// Nr for a 128-bit key
	localparam int unsigned AES_ROUNDS = 10;
	// wide enough to count to AES_ROUNDS
	localparam int unsigned ROUND_CNT_W = 4;

endpackage

//--- hdl/aes_math_pkg.sv
/*
 * GF(2^8) arithmetic and the AES round transforms as pure functions.
 * Shared by the key schedule, the state path and the byte substitution.
 */

package aes_math_pkg;

	import aes_types_pkg::*;

	// x^8 + x^4 + x^3 + x + 1, top bit dropped
	localparam aes_byte_t GF_POLY = 8'h1B;
	// Rcon for the first key expansion round
	localparam aes_byte_t RCON_INIT = 8'h01;
	// constant term of the S-box affine map
	localparam aes_byte_t SBOX_AFFINE_C = 8'h63;

	////////////////////////////////////////////////////////////////////////////
	// field arithmetic
	////////////////////////////////////////////////////////////////////////////

	// multiply by x, reduce on overflow
	function automatic aes_byte_t gf_xtime(aes_byte_t a);
		return {a[6:0], 1'b0} ^ (a[7] ? GF_POLY : 8'h00);
	endfunction

	// shift and add product
	function automatic aes_byte_t gf_mul(aes_byte_t a, aes_byte_t b);
		aes_byte_t acc;
		aes_byte_t term;
		acc = 8'h00;
		term = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc ^= term;
			term = gf_xtime(term);
		end
		return acc;
	endfunction

	// a^254 == a^-1, built from a^2 * a^4 * ... * a^128
	// zero falls out as zero
	function automatic aes_byte_t gf_inverse(aes_byte_t a);
		aes_byte_t power;
		aes_byte_t acc;
		power = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++) begin
			power = gf_mul(power, power);
			acc = gf_mul(acc, power);
		end
		return acc;
	endfunction

	// inverse then affine map: b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
	function automatic aes_byte_t sbox_byte(aes_byte_t a);
		aes_byte_t inv;
		inv = gf_inverse(a);
		return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
			{inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ SBOX_AFFINE_C;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// word and block transforms
	////////////////////////////////////////////////////////////////////////////

	// RotWord, [a0 a1 a2 a3] -> [a1 a2 a3 a0]
	function automatic aes_word_t rot_word(aes_word_t w);
		return {w[1], w[2], w[3], w[0]};
	endfunction

	// row r moves left by r columns
	function automatic aes_block_t shift_rows_block(aes_block_t s);
		aes_block_t res;
		for (int c = 0; c < 4; c++)
			for (int r = 0; r < 4; r++)
				res[c][r] = s[(c + r) % 4][r];
		return res;
	endfunction

	// lightweight form, one xtime per output byte
	function automatic aes_word_t mix_column_word(aes_word_t a);
		aes_byte_t tmp;
		aes_word_t res;
		tmp = a[0] ^ a[1] ^ a[2] ^ a[3];
		for (int r = 0; r < 4; r++)
			res[r] = a[r] ^ tmp ^ gf_xtime(a[r] ^ a[(r + 1) % 4]);
		return res;
	endfunction

	function automatic aes_block_t mix_columns_block(aes_block_t s);
		aes_block_t res;
		for (int c = 0; c < 4; c++)
			res[c] = mix_column_word(s[c]);
		return res;
	endfunction

endpackage

//--- hdl/byte_substitute.sv
/*
 * Combinational S-box over every byte of a payload.
 * Used for SubWord (one column) and SubBytes (whole block).
 */

`timescale 1ns/10ps

module byte_substitute #(
	parameter type payload_t = aes_types_pkg::aes_word_t
) (
	input  payload_t data_in,
	output payload_t data_out
);

	import aes_math_pkg::*;

	// payload size in bytes, 4 for a word, 16 for a block
	localparam int NUM_BYTES = $bits(payload_t) / 8;

	// flat views so any packed payload can be walked bytewise
	logic [$bits(payload_t)-1:0] bytes_in;
	logic [$bits(payload_t)-1:0] bytes_out;

	assign bytes_in = data_in;

	// byte position does not matter, each one goes through the same S-box
	always_comb begin
		for (int i = 0; i < NUM_BYTES; i++)
			bytes_out[8*i +: 8] = sbox_byte(bytes_in[8*i +: 8]);
	end

	assign data_out = payload_t'(bytes_out);

endmodule

//--- hdl/aes_key_expand.sv
/*
 * Key schedule that produces one round key per step.
 * Holds the current round key and Rcon and presents the next round key combinationally.
 */

`timescale 1ns/10ps

module aes_key_expand (
	input  logic                      clk,
	input  logic                      reset,
	input  aes_types_pkg::round_ctrl_t ctrl,
	input  aes_types_pkg::aes_block_t  key,
	output aes_types_pkg::aes_block_t  next_key
);

	import aes_types_pkg::*;
	import aes_math_pkg::*;

	// current round key whose w[3] feeds the g() function
	aes_block_t round_key;
	// Rcon byte that doubles every round
	aes_byte_t  rcon_q;

	aes_word_t  rotated;
	aes_word_t  sub_word;

	////////////////////////////////////////////////////////////////////////////
	// next round key
	////////////////////////////////////////////////////////////////////////////

	assign rotated = rot_word(round_key[3]);

	byte_substitute #(
		.payload_t(aes_word_t)
	) u_sub_word (
		.data_in (rotated),
		.data_out(sub_word)
	);

	// w0' = w0 ^ SubWord(RotWord(w3)) ^ Rcon
	// each later word chains on the one before
	always_comb begin
		next_key[0] = round_key[0] ^ sub_word ^ {rcon_q, 24'h000000};
		next_key[1] = round_key[1] ^ next_key[0];
		next_key[2] = round_key[2] ^ next_key[1];
		next_key[3] = round_key[3] ^ next_key[2];
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	// Rcon starts at RCON_INIT on load and moves on by xtime with each step
	always_ff @(posedge clk) begin
		if (reset)
			rcon_q <= 8'h00;
		else if (ctrl.load)
			rcon_q <= RCON_INIT;
		else if (ctrl.step)
			rcon_q <= gf_xtime(rcon_q);
	end

	// round 0 key is the cipher key itself
	always_ff @(posedge clk) begin
		if (ctrl.load)
			round_key <= key;
		else if (ctrl.step)
			round_key <= next_key;
	end

endmodule

//--- hdl/aes_state_round.sv
/*
 * Cipher state register and the round transform around it.
 * Load does the initial AddRoundKey and each step does one full or final round.
 */

`timescale 1ns/10ps

module aes_state_round (
	input  logic                      clk,
	input  logic                      reset,
	input  aes_types_pkg::round_ctrl_t ctrl,
	input  aes_types_pkg::aes_block_t  plaintext,
	input  aes_types_pkg::aes_block_t  key,
	input  aes_types_pkg::aes_block_t  next_key,
	output aes_types_pkg::aes_block_t  state
);

	import aes_types_pkg::*;
	import aes_math_pkg::*;

	aes_block_t sub_bytes;
	aes_block_t shifted;
	aes_block_t mixed;
	aes_block_t round_out;

	////////////////////////////////////////////////////////////////////////////
	// round transform
	////////////////////////////////////////////////////////////////////////////

	// SubBytes on all sixteen bytes
	byte_substitute #(
		.payload_t(aes_block_t)
	) u_sub_bytes (
		.data_in (state),
		.data_out(sub_bytes)
	);

	assign shifted = shift_rows_block(sub_bytes);
	assign mixed   = mix_columns_block(shifted);

	// last round goes straight from ShiftRows to AddRoundKey
	// next_key is the key for this round
	// the key schedule registers it on the same edge
	assign round_out = (ctrl.final_round ? shifted : mixed) ^ next_key;

	////////////////////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////////////////////

	// load adds the round 0 key and each step runs one round
	always_ff @(posedge clk) begin
		if (reset)
			state <= '0;
		else if (ctrl.load)
			state <= plaintext ^ key;
		else if (ctrl.step)
			state <= round_out;
	end

endmodule

//--- hdl/aes_round_ctrl.sv
/*
 * Round sequencer and four-phase req/ack handshake.
 * Drives load, step and final_round, ack follows 11 cycles after the load edge.
 */

`timescale 1ns/10ps

module aes_round_ctrl (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       req,
	output logic                       ack,
	output aes_types_pkg::round_ctrl_t ctrl
);

	import aes_types_pkg::*;

	// IDLE waits for req low after reset, LOAD accepts a block on the first req seen
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ROUNDS,
		ST_DONE
	} ctrl_state_t;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	// number of the round in progress, 1 to AES_ROUNDS
	logic [ROUND_CNT_W-1:0] round_cnt;
	logic                   last_round;

	assign last_round = (round_cnt == ROUND_CNT_W'(AES_ROUNDS));

	////////////////////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			// a req left high across reset belongs to an abandoned block
			ST_IDLE:   if (!req) state_d = ST_LOAD;
			ST_LOAD:   if (req) state_d = ST_ROUNDS;
			ST_ROUNDS: if (last_round) state_d = ST_DONE;
			// hold result until the requester lets go
			ST_DONE:   if (!req) state_d = ST_LOAD;
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// counter restarts at 1 on the load edge
	always_ff @(posedge clk) begin
		if (reset)
			round_cnt <= '0;
		else if (ctrl.load)
			round_cnt <= ROUND_CNT_W'(1);
		else if (ctrl.step)
			round_cnt <= round_cnt + ROUND_CNT_W'(1);
	end

	// rises the edge after the final round, drops on the first edge with req low
	always_ff @(posedge clk) begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= (state_q == ST_DONE) && req;
	end

	////////////////////////////////////////////////////////////////////////////
	// datapath control
	////////////////////////////////////////////////////////////////////////////

	assign ctrl.load        = (state_q == ST_LOAD) && req;
	assign ctrl.step        = (state_q == ST_ROUNDS);
	assign ctrl.final_round = (state_q == ST_ROUNDS) && last_round;

endmodule

//--- hdl/aes_top.sv
/*
 * Iterative AES-128 encryption engine, one round per clock.
 * Present key and plaintext with req, read ciphertext while ack is high.
 */

`timescale 1ns/10ps

module aes_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        req,
	input  aes_types_pkg::aes_request_t request,
	output logic                        ack,
	output aes_types_pkg::aes_block_t   ciphertext
);

	import aes_types_pkg::*;

	// one control bundle fans out to both datapath halves
	round_ctrl_t ctrl;
	// round key for the round in progress
	aes_block_t  next_key;

	aes_round_ctrl u_ctrl (
		.clk  (clk),
		.reset(reset),
		.req  (req),
		.ack  (ack),
		.ctrl (ctrl)
	);

	aes_key_expand u_key_expand (
		.clk     (clk),
		.reset   (reset),
		.ctrl    (ctrl),
		.key     (request.key),
		.next_key(next_key)
	);

	// state register doubles as the ciphertext output
	aes_state_round u_state_round (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrl),
		.plaintext(request.plaintext),
		.key      (request.key),
		.next_key (next_key),
		.state    (ciphertext)
	);

endmodule

//--- verif/tb_clock_gen.sv
/*
 * Testbench clock and power-on reset.
 * 100 ns clock, reset held for the first 10 rising edges.
 */

`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// half of the 100 ns period
	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 10;
	// same offset the testbench uses for its own inputs
	localparam int DRIVE_DELAY = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// released just after the 10th rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
	end

endmodule

//--- verif/aes_tb.sv
/*
 * Testbench for the AES-128 engine. Runs known-answer vectors from a file
 * through the req/ack handshake with random gaps and hold times, checks
 * ciphertext, latency, back-pressure and recovery from a mid-block reset.
 */

`timescale 1ns/10ps

module aes_tb;

	import aes_types_pkg::*;

	localparam int DRIVE_DELAY = 10;
	localparam int MAX_VECTORS = 16;
	// edges from the load edge to ack
	localparam int ACK_LATENCY = 11;
	localparam int ACK_TIMEOUT = 40;
	localparam int RESET_TIMEOUT = 50;
	localparam int IDLE_CYCLES = 20;
	localparam int ABORT_RESET_CYCLES = 3;
	// longer than a whole block, so a wrongly started block would show
	localparam int STALE_REQ_CYCLES = 15;
	localparam logic [31:0] LFSR_SEED = 32'hd498;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic         clk;
	logic         por_reset;
	logic         abort_reset;
	logic         reset;
	logic         req;
	aes_request_t request;
	logic         ack;
	aes_block_t   ciphertext;

	// three entries per vector: key, plaintext, expected ciphertext
	logic [127:0] vectors [0:3*MAX_VECTORS-1];
	int           num_vectors;
	logic [31:0]  lfsr;
	int           error_count;
	int           test_count;
	int           failed_tests;

	// power-on reset from the clock module, abort pulses from the test
	assign reset = por_reset | abort_reset;

	tb_clock_gen u_clock_gen (
		.clk  (clk),
		.reset(por_reset)
	);

	aes_top UUT (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.request   (request),
		.ack       (ack),
		.ciphertext(ciphertext)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// drive and sample slot, a fixed delay after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Galois step, bit 0 is the output bit
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic random_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// junk on the request bus while req is low, must be ignored
	task automatic scramble_request();
		aes_request_t junk;
		junk = '0;
		for (int i = 0; i < $bits(aes_request_t); i++) begin
			junk = {junk[$bits(aes_request_t)-2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		request = junk;
	endtask

	// marks unwritten entries, different at every address
	function automatic logic [127:0] fill_entry(int addr);
		logic [31:0] a;
		a = addr;
		return {a ^ 32'hc3a5_0f1e, ~a, a * 32'h9e37_79b9, a + 32'h0bad_f00d};
	endfunction

	task automatic load_vectors();
		for (int i = 0; i < 3 * MAX_VECTORS; i++)
			vectors[i] = fill_entry(i);
		$readmemh("verif/aes_vectors.txt", vectors);
		num_vectors = 0;
		while (num_vectors < MAX_VECTORS &&
				vectors[3*num_vectors] != fill_entry(3 * num_vectors))
			num_vectors++;
		if (num_vectors == 0) begin
			$display("no vectors could be read from verif/aes_vectors.txt");
			error_count++;
		end else if (vectors[3*num_vectors-1] == fill_entry(3 * num_vectors - 1)) begin
			$display("last line of verif/aes_vectors.txt has fewer than three values");
			error_count++;
			num_vectors--;
		end
	endtask

	// one line per finished test
	task automatic report_test(input string label, input string detail, input int start_errors);
		test_count++;
		if (error_count == start_errors) begin
			$display("%s: ok %s", label, detail);
		end else begin
			failed_tests++;
			$display("%s: failed with %0d errors", label, error_count - start_errors);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		int  start_errors;
		int  cycles;
		logic reset_low;
		start_errors = error_count;
		cycles = 0;
		reset_low = 1'b0;
		// reset is read at the edge, where it has been stable since the last slot
		while (!reset_low && cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			reset_low = (reset === 1'b0);
			#DRIVE_DELAY;
			cycles++;
			if (ack !== 1'b0) begin
				$display("CHECK FAILED: ack is %h during reset, expected %h", ack, 1'b0);
				error_count++;
			end
		end
		if (!reset_low) begin
			$display("reset was still high after %0d cycles", RESET_TIMEOUT);
			error_count++;
		end
		// no req, so nothing may happen
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			next_cycle();
			if (ack !== 1'b0) begin
				$display("CHECK FAILED: ack is %h while idle, expected %h", ack, 1'b0);
				error_count++;
			end
		end
		report_test("reset state", "", start_errors);
	endtask

	// full handshake for one vector, then back-pressure and an idle gap
	task automatic run_block(input int idx, input string label);
		aes_block_t expected;
		aes_block_t held;
		int         start_errors;
		int         cycles;
		int         hold;
		int         gap;
		start_errors = error_count;
		hold = 0;
		gap = 0;
		expected = vectors[3*idx+2];
		request.key = vectors[3*idx];
		request.plaintext = vectors[3*idx+1];
		req = 1'b1;
		// the next edge is the load edge
		cycles = 0;
		while (ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (ack !== 1'b1) begin
			$display("%s: ack did not rise within %0d cycles of req", label, ACK_TIMEOUT);
			error_count++;
			req = 1'b0;
			next_cycle();
		end else begin
			if (cycles - 1 != ACK_LATENCY) begin
				$display("CHECK FAILED: ack latency is %h cycles, expected %h",
					cycles - 1, ACK_LATENCY);
				error_count++;
			end
			if (ciphertext !== expected) begin
				$display("CHECK FAILED: ciphertext is %h, expected %h", ciphertext, expected);
				error_count++;
			end
			// requester keeps req high, result must be frozen
			held = ciphertext;
			random_bits(4, hold);
			hold = hold % 15 + 1;
			for (int i = 0; i < hold; i++) begin
				next_cycle();
				if (ack !== 1'b1) begin
					$display("CHECK FAILED: ack is %h while req held, expected %h", ack, 1'b1);
					error_count++;
				end
				if (ciphertext !== held) begin
					$display("CHECK FAILED: ciphertext is %h while req held, expected %h",
						ciphertext, held);
					error_count++;
				end
			end
			req = 1'b0;
			scramble_request();
			// ack drops on the edge that sees req low
			next_cycle();
			if (ack !== 1'b0) begin
				$display("CHECK FAILED: ack is %h after req dropped, expected %h", ack, 1'b0);
				error_count++;
			end
			// gap of zero starts the next block right away
			random_bits(2, gap);
			for (int i = 0; i < gap; i++) begin
				next_cycle();
				if (ack !== 1'b0) begin
					$display("CHECK FAILED: ack is %h in idle gap, expected %h", ack, 1'b0);
					error_count++;
				end
			end
		end
		report_test(label, $sformatf("(latency %0d, held %0d, gap %0d)", cycles - 1, hold, gap),
			start_errors);
	endtask

	// reset lands in the middle of the rounds, req stays high across it
	task automatic test_abort(input int idx);
		int start_errors;
		int run_cycles;
		start_errors = error_count;
		request.key = vectors[3*idx];
		request.plaintext = vectors[3*idx+1];
		req = 1'b1;
		// 1 to 8 edges, always short of ack
		random_bits(3, run_cycles);
		run_cycles = run_cycles + 1;
		for (int i = 0; i < run_cycles + ABORT_RESET_CYCLES + STALE_REQ_CYCLES; i++) begin
			if (i == run_cycles)
				abort_reset = 1'b1;
			if (i == run_cycles + ABORT_RESET_CYCLES)
				abort_reset = 1'b0;
			next_cycle();
			if (ack !== 1'b0) begin
				$display("CHECK FAILED: ack is %h around abort, expected %h", ack, 1'b0);
				error_count++;
			end
		end
		// one edge with req low lets the controller accept again
		req = 1'b0;
		next_cycle();
		if (ack !== 1'b0) begin
			$display("CHECK FAILED: ack is %h after abort, expected %h", ack, 1'b0);
			error_count++;
		end
		report_test("abort", $sformatf("(reset after %0d cycles)", run_cycles), start_errors);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		req = 1'b0;
		request = '0;
		abort_reset = 1'b0;
		lfsr = LFSR_SEED;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;

		load_vectors();
		test_reset_state();

		if (num_vectors > 0) begin
			for (int i = 0; i < num_vectors; i++)
				run_block(i, $sformatf("vector %0d", i));
			// reverse order, so each block follows a different predecessor
			for (int i = num_vectors - 1; i >= 0; i--)
				run_block(i, $sformatf("vector %0d repeat", i));
			test_abort(0);
			run_block(num_vectors - 1, "vector after abort");
		end

		$display("tests run: %0d, tests failed: %0d, checks failed: %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- verif/aes_vectors.txt
// AES-128 known answers, one vector per line, 128-bit hex each
// columns: key  plaintext  expected ciphertext
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4

//--- flist.f
hdl/aes_types_pkg.sv
hdl/aes_math_pkg.sv
hdl/byte_substitute.sv
hdl/aes_key_expand.sv
hdl/aes_state_round.sv
hdl/aes_round_ctrl.sv
hdl/aes_top.sv
verif/tb_clock_gen.sv
verif/aes_tb.sv

//--- Makefile
# Verilator build and run of the AES-128 testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module aes_tb -Mdir obj_dir

run: compile
	./obj_dir/Vaes_tb | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log
